/* common/mcsr_consts.svh */
// machine CSR constants
`ifndef MCSR_CONSTS_SVH
`define MCSR_CONSTS_SVH

`define XLEN              64
`define CSR_ADDR_W        12

// csr addresses
`define CSR_MCYCLE        12'hb00
`define CSR_MSTATUS       12'h300
`define CSR_MTVEC         12'h305
`define CSR_MEPC          12'h341
`define CSR_MCAUSE        12'h342
`define CSR_MIE           12'h304
`define CSR_MIP           12'h344
`define CSR_MSCRATCH      12'h340

// trap causes, bit 63 marks an interrupt
`define CAUSE_ECALL_M     64'h0000_0000_0000_000b
`define CAUSE_M_TIMER_INT 64'h8000_0000_0000_0007

`define MTIP_BIT          7           // timer bit in mie / mip
`define MPP_MACHINE       2'b11
`define FS_DIRTY          2'b11
`define MTVEC_MODE_DIRECT 2'b00

`endif

/* common/mcsr_pkg.sv */
// machine CSR types
`include "mcsr_consts.svh"

package mcsr_pkg;

    // one software access to the csr file
    typedef struct packed {
        logic                   rd_en;
        logic                   wr_en;
        logic [`CSR_ADDR_W-1:0] idx;
        logic [`XLEN-1:0]       wdata;
    } csr_req_t;

    // mstatus fields, reserved bits kept as gaps
    typedef struct packed {
        logic        sd;          // 63
        logic [45:0] rsvd_62_17;
        logic [1:0]  xs;          // 16:15
        logic [1:0]  fs;          // 14:13
        logic [1:0]  mpp;         // 12:11
        logic [2:0]  rsvd_10_8;
        logic        mpie;        // 7
        logic [2:0]  rsvd_6_4;
        logic        mie;         // 3
        logic [2:0]  rsvd_2_0;
    } mstatus_fields_t;

    typedef union packed {
        logic [`XLEN-1:0] raw;
        mstatus_fields_t  f;
    } mstatus_t;

    // trap entry or mret, decided by the trap controller
    typedef struct packed {
        logic             take;
        logic             ret;
        logic [`XLEN-1:0] cause;
        logic [`XLEN-1:0] epc;
    } trap_evt_t;

    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] pc;
    } redirect_t;

    // what the trap controller needs from the csr file
    typedef struct packed {
        logic             mstatus_mie;
        logic             mie_mtie;
        logic             mip_mtip;
        logic [`XLEN-1:0] mtvec;
        logic [`XLEN-1:0] mepc;
    } irq_state_t;

endpackage

/* design/mtimer.sv */
// machine timer
`timescale 1ns/100ps
`include "mcsr_consts.svh"

module mtimer (
    input  logic             clk,
    input  logic             wr_mscrstch,
    input  logic             cmp_wr,
    input  logic [`XLEN-1:0] cmp_data,
    output logic             timer_irq
);

    logic [`XLEN-1:0] mtime;
    logic [`XLEN-1:0] mtimecmp;

    always_ff @(posedge clk) begin
        if (wr_mscrstch) begin
            mtime <= '0;
        end else begin
            mtime <= mtime + 1'b1;
        end
    end

    // all ones after reset keeps the interrupt quiet
    always_ff @(posedge clk) begin
        if (wr_mscrstch) begin
            mtimecmp <= '1;
        end else if (cmp_wr) begin
            mtimecmp <= cmp_data;
        end
    end

    // registered level, sees a new compare one cycle after the write
    always_ff @(posedge clk) begin
        if (wr_mscrstch) begin
            timer_irq <= 1'b0;
        end else begin
            timer_irq <= (mtime >= mtimecmp);
        end
    end

endmodule

/* csr_regs/mcsr_regs.sv */
// machine CSR register file
`timescale 1ns/100ps
`include "mcsr_consts.svh"

module mcsr_regs import mcsr_pkg::*; (
    input  logic             clk,
    input  logic             wr_mscrstch,
    input  csr_req_t         csr_req,
    input  trap_evt_t        trap,
    input  logic             timer_irq,
    output logic [`XLEN-1:0] csr_rdata,
    output irq_state_t       irq
);

    logic             we_mcycle;
    logic             we_mstatus;
    logic             we_mtvec;
    logic             we_mepc;
    logic             we_mcause;
    logic             we_mie;
    logic             we_mscratch;

    logic [`XLEN-1:0] mcycle;
    mstatus_t         mstatus_q;
    mstatus_t         mstatus_d;
    mstatus_t         mstatus_wr;
    logic [`XLEN-1:2] mtvec_base;
    logic [`XLEN-1:2] mepc_base;
    logic [`XLEN-1:0] mcause;
    logic             mie_mtie;
    logic             mip_mtip;
    logic [`XLEN-1:0] mscratch;

    // write decode
    assign we_mcycle   = csr_req.wr_en && (csr_req.idx == `CSR_MCYCLE);
    assign we_mstatus  = csr_req.wr_en && (csr_req.idx == `CSR_MSTATUS);
    assign we_mtvec    = csr_req.wr_en && (csr_req.idx == `CSR_MTVEC);
    assign we_mepc     = csr_req.wr_en && (csr_req.idx == `CSR_MEPC);
    assign we_mcause   = csr_req.wr_en && (csr_req.idx == `CSR_MCAUSE);
    assign we_mie      = csr_req.wr_en && (csr_req.idx == `CSR_MIE);
    assign we_mscratch = csr_req.wr_en && (csr_req.idx == `CSR_MSCRATCH);

    always_ff @(posedge clk) begin
        if (wr_mscrstch) begin
            mcycle <= '0;
        end else if (we_mcycle) begin
            mcycle <= csr_req.wdata;
        end else begin
            mcycle <= mcycle + 1'b1;   // free running
        end
    end

    // trap entry wins over mret, both win over a software write
    always_comb begin
        mstatus_wr.raw = csr_req.wdata;
        mstatus_d      = mstatus_q;
        if (trap.take) begin
            mstatus_d.f.mpie = mstatus_q.f.mie;
            mstatus_d.f.mie  = 1'b0;
            mstatus_d.f.mpp  = `MPP_MACHINE;
        end else if (trap.ret) begin
            mstatus_d.f.mie  = mstatus_q.f.mpie;
            mstatus_d.f.mpie = 1'b1;
            mstatus_d.f.mpp  = 2'b00;
        end else if (we_mstatus) begin
            mstatus_d.raw    = '0;         // xs and reserved read zero
            mstatus_d.f.fs   = mstatus_wr.f.fs;
            mstatus_d.f.mpp  = mstatus_wr.f.mpp;
            mstatus_d.f.mpie = mstatus_wr.f.mpie;
            mstatus_d.f.mie  = mstatus_wr.f.mie;
            mstatus_d.f.sd   = (mstatus_wr.f.fs == `FS_DIRTY);
        end
    end

    always_ff @(posedge clk) begin
        if (wr_mscrstch) begin
            mstatus_q  <= '0;
            mtvec_base <= '0;
            mepc_base  <= '0;
            mcause     <= '0;
            mie_mtie   <= 1'b0;
            mip_mtip   <= 1'b0;
            mscratch   <= '0;
        end else begin
            mstatus_q <= mstatus_d;
            mip_mtip  <= timer_irq;    // one cycle behind the timer
            if (we_mtvec) mtvec_base <= csr_req.wdata[`XLEN-1:2];
            if (trap.take) begin
                mepc_base <= trap.epc[`XLEN-1:2];
                mcause    <= trap.cause;
            end else begin
                if (we_mepc)   mepc_base <= csr_req.wdata[`XLEN-1:2];
                if (we_mcause) mcause    <= csr_req.wdata;
            end
            if (we_mie)      mie_mtie <= csr_req.wdata[`MTIP_BIT];
            if (we_mscratch) mscratch <= csr_req.wdata;
        end
    end

    // read port, zero when idle or unmapped
    always_comb begin
        csr_rdata = '0;
        if (csr_req.rd_en) begin
            case (csr_req.idx)
                `CSR_MCYCLE:   csr_rdata = mcycle;
                `CSR_MSTATUS:  csr_rdata = mstatus_q.raw;
                `CSR_MTVEC:    csr_rdata = {mtvec_base, `MTVEC_MODE_DIRECT};
                `CSR_MEPC:     csr_rdata = {mepc_base, 2'b00};
                `CSR_MCAUSE:   csr_rdata = mcause;
                `CSR_MIE:      csr_rdata[`MTIP_BIT] = mie_mtie;
                `CSR_MIP:      csr_rdata[`MTIP_BIT] = mip_mtip;
                `CSR_MSCRATCH: csr_rdata = mscratch;
                default:       csr_rdata = '0;
            endcase
        end
    end

    assign irq.mstatus_mie = mstatus_q.f.mie;
    assign irq.mie_mtie    = mie_mtie;
    assign irq.mip_mtip    = mip_mtip;
    assign irq.mtvec       = {mtvec_base, `MTVEC_MODE_DIRECT};
    assign irq.mepc        = {mepc_base, 2'b00};

endmodule

/* design/trap_ctrl.sv */
// trap and return controller
`timescale 1ns/100ps
`include "mcsr_consts.svh"

module trap_ctrl import mcsr_pkg::*; (
    input  irq_state_t       irq,
    input  logic [`XLEN-1:0] pc,
    input  logic             ecall,
    input  logic             mret,
    input  logic             ex_stall,
    output trap_evt_t        trap,
    output redirect_t        redirect
);

    logic irq_pend;
    logic take_int;
    logic take_ecall;
    logic take_ret;

    // pc of zero means no valid instruction in commit
    assign irq_pend = irq.mip_mtip && irq.mstatus_mie && irq.mie_mtie
                      && (pc != '0);

    // interrupt, then ecall, then mret
    assign take_int   = !ex_stall && irq_pend;
    assign take_ecall = !ex_stall && !irq_pend && ecall;
    assign take_ret   = !ex_stall && !irq_pend && !ecall && mret;

    always_comb begin
        trap.take  = take_int || take_ecall;
        trap.ret   = take_ret;
        trap.cause = take_int ? `CAUSE_M_TIMER_INT : `CAUSE_ECALL_M;
        trap.epc   = pc;
    end

    always_comb begin
        redirect.valid = trap.take || trap.ret;
        if (trap.take) begin
            redirect.pc = irq.mtvec;   // direct mode only
        end else if (trap.ret) begin
            redirect.pc = irq.mepc;
        end else begin
            redirect.pc = '0;
        end
    end

endmodule

/* design/mcsr_unit.sv */
// machine CSR unit top
`timescale 1ns/100ps
`include "mcsr_consts.svh"

module mcsr_unit import mcsr_pkg::*; (
    input  logic             clk,
    input  logic             wr_mscrstch,
    input  csr_req_t         csr_req,
    input  logic [`XLEN-1:0] pc,
    input  logic             ecall,
    input  logic             mret,
    input  logic             ex_stall,
    input  logic             tmr_cmp_wr,
    input  logic [`XLEN-1:0] tmr_cmp_data,
    output logic [`XLEN-1:0] csr_rdata,
    output redirect_t        redirect
);

    logic       timer_irq;
    irq_state_t irq;
    trap_evt_t  trap;

    mtimer i_mtimer (
        .clk         (clk),
        .wr_mscrstch (wr_mscrstch),
        .cmp_wr      (tmr_cmp_wr),
        .cmp_data    (tmr_cmp_data),
        .timer_irq   (timer_irq)
    );

    mcsr_regs i_mcsr_regs (
        .clk         (clk),
        .wr_mscrstch (wr_mscrstch),
        .csr_req     (csr_req),
        .trap        (trap),
        .timer_irq   (timer_irq),
        .csr_rdata   (csr_rdata),
        .irq         (irq)
    );

    trap_ctrl i_trap_ctrl (
        .irq      (irq),
        .pc       (pc),
        .ecall    (ecall),
        .mret     (mret),
        .ex_stall (ex_stall),
        .trap     (trap),
        .redirect (redirect)
    );

endmodule

/* sim/mcsr_unit_props.sv */
// CSR unit assertions
`timescale 1ns/100ps

module mcsr_unit_props import mcsr_pkg::*; (
    input logic      clk,
    input logic      wr_mscrstch,
    input logic      ex_stall,
    input trap_evt_t trap,
    input redirect_t redirect
);

    // a stall holds back every redirect
    a_stall_quiet: assert property (
        @(posedge clk) disable iff (wr_mscrstch) ex_stall |-> !redirect.valid
    ) else $error("redirect raised during a stall");

    a_take_or_ret: assert property (
        @(posedge clk) disable iff (wr_mscrstch) !(trap.take && trap.ret)
    ) else $error("trap entry and return in the same cycle");

    // first cycle out of reset
    a_reset_quiet: assert property (
        @(posedge clk) $fell(wr_mscrstch) |-> !redirect.valid
    ) else $error("redirect raised right after reset");

endmodule

/* sim/mcsr_unit_tb.sv */
// machine CSR unit testbench
`timescale 1ns/100ps
`include "mcsr_consts.svh"

module mcsr_unit_tb import mcsr_pkg::*; ();

    logic             clk;
    logic             wr_mscrstch;
    csr_req_t         csr_req;
    logic [`XLEN-1:0] pc;
    logic             ecall;
    logic             mret;
    logic             ex_stall;
    logic             tmr_cmp_wr;
    logic [`XLEN-1:0] tmr_cmp_data;
    logic [`XLEN-1:0] csr_rdata;
    redirect_t        redirect;

    logic [31:0]      lfsr_q;
    logic [`XLEN-1:0] cyc;        // cycles since reset, tracks mtime
    logic [`XLEN-1:0] exp_tvec;
    logic [`XLEN-1:0] exp_epc;

    mcsr_unit i_mcsr_unit (
        .clk          (clk),
        .wr_mscrstch  (wr_mscrstch),
        .csr_req      (csr_req),
        .pc           (pc),
        .ecall        (ecall),
        .mret         (mret),
        .ex_stall     (ex_stall),
        .tmr_cmp_wr   (tmr_cmp_wr),
        .tmr_cmp_data (tmr_cmp_data),
        .csr_rdata    (csr_rdata),
        .redirect     (redirect)
    );

    bind mcsr_unit mcsr_unit_props i_mcsr_unit_props (
        .clk         (clk),
        .wr_mscrstch (wr_mscrstch),
        .ex_stall    (ex_stall),
        .trap        (trap),
        .redirect    (redirect)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        if (wr_mscrstch) cyc <= '0;
        else cyc <= cyc + 1'b1;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic rand_word(output logic [`XLEN-1:0] w);
        for (int i = 0; i < `XLEN; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            w[i]   = lfsr_q[0];
        end
    endtask

    task automatic check(input string name, input logic [`XLEN-1:0] got,
                         input logic [`XLEN-1:0] exp);
        if (got !== exp) begin
            $display("error %s got %h expected %h", name, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic give_up(input string what);
        $display("CHECKS FAILED");
        $fatal(1, "timeout, %s", what);
    endtask

    // mstatus keeps fs, mpp, mpie, mie; sd flags fs dirty
    function automatic logic [`XLEN-1:0] mstatus_legal(input logic [`XLEN-1:0] w);
        logic [`XLEN-1:0] m;
        m        = '0;
        m[14:13] = w[14:13];
        m[12:11] = w[12:11];
        m[7]     = w[7];
        m[3]     = w[3];
        m[63]    = (w[14:13] == 2'b11);
        return m;
    endfunction

    task automatic csr_write(input logic [11:0] addr, input logic [`XLEN-1:0] data);
        @(posedge clk);
        csr_req <= '{rd_en: 1'b0, wr_en: 1'b1, idx: addr, wdata: data};
        @(posedge clk);
        csr_req <= '0;
    endtask

    task automatic expect_csr(input string name, input logic [11:0] addr,
                              input logic [`XLEN-1:0] exp);
        @(posedge clk);
        csr_req <= '{rd_en: 1'b1, wr_en: 1'b0, idx: addr, wdata: '0};
        @(negedge clk);
        check(name, csr_rdata, exp);
    endtask

    task automatic test_reset_regs();
        logic [`XLEN-1:0] v;
        @(negedge clk);
        check("redirect.valid", redirect.valid, 0);
        check("csr_rdata", csr_rdata, '0);
        expect_csr("mcycle", `CSR_MCYCLE, 1);    // one count since reset dropped
        expect_csr("mstatus", `CSR_MSTATUS, '0);
        expect_csr("mtvec", `CSR_MTVEC, '0);
        expect_csr("mepc", `CSR_MEPC, '0);
        expect_csr("mcause", `CSR_MCAUSE, '0);
        expect_csr("mie", `CSR_MIE, '0);
        expect_csr("mip", `CSR_MIP, '0);
        expect_csr("mscratch", `CSR_MSCRATCH, '0);
        expect_csr("unmapped", 12'h7c0, '0);
        rand_word(v);
        csr_write(`CSR_MSCRATCH, v);
        expect_csr("mscratch", `CSR_MSCRATCH, v);
        rand_word(v);
        csr_write(`CSR_MTVEC, v);
        expect_csr("mtvec", `CSR_MTVEC, {v[`XLEN-1:2], 2'b00});
        rand_word(v);
        csr_write(`CSR_MEPC, v);
        expect_csr("mepc", `CSR_MEPC, {v[`XLEN-1:2], 2'b00});
        rand_word(v);
        csr_write(`CSR_MCYCLE, v);
        expect_csr("mcycle", `CSR_MCYCLE, v + 1);
        repeat (4) @(posedge clk);
        expect_csr("mcycle", `CSR_MCYCLE, v + 6);
    endtask

    task automatic test_mstatus();
        logic [`XLEN-1:0] v;
        rand_word(v);
        csr_write(`CSR_MSTATUS, v);
        expect_csr("mstatus", `CSR_MSTATUS, mstatus_legal(v));
        csr_write(`CSR_MSTATUS, '1);
        expect_csr("mstatus", `CSR_MSTATUS, mstatus_legal('1));
        csr_write(`CSR_MSTATUS, 64'h0000_0000_0000_2088);   // fs not dirty
        expect_csr("mstatus", `CSR_MSTATUS, mstatus_legal(64'h2088));
    endtask

    task automatic test_ecall();
        logic [`XLEN-1:0] p;
        rand_word(exp_tvec);
        csr_write(`CSR_MTVEC, exp_tvec);
        exp_tvec[1:0] = 2'b00;
        csr_write(`CSR_MSTATUS, 64'h8);   // mie on, mpie off
        rand_word(p);
        p = p | 64'h1;
        exp_epc = {p[`XLEN-1:2], 2'b00};
        @(posedge clk);
        pc    <= p;
        ecall <= 1'b1;
        @(negedge clk);
        check("redirect.valid", redirect.valid, 1);
        check("redirect.pc", redirect.pc, exp_tvec);
        @(posedge clk);
        ecall   <= 1'b0;
        csr_req <= '{rd_en: 1'b1, wr_en: 1'b0, idx: `CSR_MEPC, wdata: '0};
        @(negedge clk);
        check("mepc", csr_rdata, exp_epc);
        expect_csr("mcause", `CSR_MCAUSE, 64'd11);
        expect_csr("mstatus", `CSR_MSTATUS, 64'h1880);   // mpp 3, mpie 1, mie 0
    endtask

    task automatic test_mret();
        @(posedge clk);
        mret <= 1'b1;
        pc   <= pc + 4;
        @(negedge clk);
        check("redirect.valid", redirect.valid, 1);
        check("redirect.pc", redirect.pc, exp_epc);
        @(posedge clk);
        mret    <= 1'b0;
        csr_req <= '{rd_en: 1'b1, wr_en: 1'b0, idx: `CSR_MSTATUS, wdata: '0};
        @(negedge clk);
        check("mstatus", csr_rdata, 64'h88);   // mie from mpie, mpie 1, mpp 0
    endtask

    task automatic test_timer();
        logic [`XLEN-1:0] target;
        int               n;
        csr_write(`CSR_MIE, 64'h1 << `MTIP_BIT);
        csr_write(`CSR_MSTATUS, 64'h8);
        exp_epc = {pc[`XLEN-1:2], 2'b00};
        @(posedge clk);
        target = cyc + 16;
        tmr_cmp_wr   <= 1'b1;
        tmr_cmp_data <= target;
        @(posedge clk);
        tmr_cmp_wr <= 1'b0;
        n = 0;
        @(negedge clk);
        while (!redirect.valid && n < 200) begin
            @(negedge clk);
            n++;
        end
        if (!redirect.valid) give_up("no redirect from the timer interrupt");
        // registered level, then mip, then redirect
        check("irq latency", cyc, target + 2);
        check("redirect.pc", redirect.pc, exp_tvec);
        expect_csr("mcause", `CSR_MCAUSE, `CAUSE_M_TIMER_INT);
        expect_csr("mepc", `CSR_MEPC, exp_epc);
    endtask

    task automatic test_stall();
        logic [`XLEN-1:0] p;
        rand_word(p);
        p = p | 64'h2;
        @(posedge clk);
        ex_stall <= 1'b1;
        ecall    <= 1'b1;
        pc       <= p;
        repeat (3) begin
            @(negedge clk);
            check("redirect.valid", redirect.valid, 0);
        end
        expect_csr("mepc", `CSR_MEPC, exp_epc);
        expect_csr("mcause", `CSR_MCAUSE, `CAUSE_M_TIMER_INT);
        @(posedge clk);
        ex_stall <= 1'b0;   // ecall still held
        @(negedge clk);
        check("redirect.valid", redirect.valid, 1);
        check("redirect.pc", redirect.pc, exp_tvec);
        @(posedge clk);
        ecall <= 1'b0;
        expect_csr("mepc", `CSR_MEPC, {p[`XLEN-1:2], 2'b00});
        expect_csr("mcause", `CSR_MCAUSE, `CAUSE_ECALL_M);
    endtask

    initial begin
        #200000;
        give_up("the run did not finish");
    end

    initial begin
        lfsr_q       = 32'd10;
        wr_mscrstch  = 1'b1;
        csr_req      = '0;
        pc           = '0;
        ecall        = 1'b0;
        mret         = 1'b0;
        ex_stall     = 1'b0;
        tmr_cmp_wr   = 1'b0;
        tmr_cmp_data = '0;
        repeat (10) @(posedge clk);
        wr_mscrstch <= 1'b0;
        test_reset_regs();
        test_mstatus();
        test_ecall();
        test_mret();
        test_timer();
        test_stall();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* mcsr_unit.f */
+incdir+common
common/mcsr_pkg.sv
design/mtimer.sv
csr_regs/mcsr_regs.sv
design/trap_ctrl.sv
design/mcsr_unit.sv
sim/mcsr_unit_props.sv
sim/mcsr_unit_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := mcsr_unit_tb
FILELIST  := mcsr_unit.f
OBJ_DIR   := obj_dir

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS := $(wildcard common/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
